// ==== hw/eq_pkg.sv ====
package eq_pkg;

    // ========================================================================
    // Fixed-point format
    // ========================================================================
    localparam int COEF_FRAC = 14;      // Fraction bits of a Q2.14 tap
    localparam int COEF_ONE  = 16384;   // Unity gain in Q2.14
    localparam int SAMPLE_W  = 16;      // Filtered audio path

    // ========================================================================
    // Filter coefficients
    // ========================================================================
    // Taps of one biquad section
    // B taps feed forward and a taps feed back
    typedef struct packed {
        logic signed [15:0] b0;
        logic signed [15:0] b1;
        logic signed [15:0] b2;
        logic signed [15:0] a1;
        logic signed [15:0] a2;
    } coef_t;

    typedef struct packed {
        coef_t low;
        coef_t mid;
        coef_t high;
    } coef_bank_t;

    // ========================================================================
    // SPI write frame
    // ========================================================================
    // Band number in addr[7:4] and tap number in addr[3:0]
    typedef struct packed {
        logic [7:0]  addr;
        logic [15:0] data;
    } spi_frame_t;

endpackage

// ==== hw/spi_coef_regs.sv ====
module spi_coef_regs (
    input  logic               lmmi_clk_i,
    input  logic               reset_n_i,
    input  logic               spi_sck_i,
    input  logic               spi_sdi_i,
    input  logic               spi_cs_n_i,
    output eq_pkg::coef_bank_t coefs_o
);
    import eq_pkg::*;

    localparam int FRAME_BITS = $bits(spi_frame_t);

    logic [2:0] sck_sync;       // Two sync stages plus one for edge detect
    logic [2:0] cs_sync;
    logic [1:0] sdi_sync;
    logic       sck_rise;
    logic       cs_rise;
    logic       cs_active;
    logic [4:0] bit_cnt;
    spi_frame_t frame;
    logic [3:0] band;
    logic [3:0] tap;
    logic       addr_ok;
    logic       commit;

    // Section with one tap replaced
    function automatic coef_t set_tap(input coef_t c, input logic [3:0] sel,
                                      input logic signed [15:0] d);
        coef_t r;
        r = c;
        case (sel)
            4'd0:    r.b0 = d;
            4'd1:    r.b1 = d;
            4'd2:    r.b2 = d;
            4'd3:    r.a1 = d;
            4'd4:    r.a2 = d;
            default: r = c;
        endcase
        return r;
    endfunction

    // ========================================================================
    // Pin synchronizers
    // ========================================================================
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            sck_sync <= '0;
            cs_sync  <= '1;     // Bus idles deselected
            sdi_sync <= '0;
        end else begin
            sck_sync <= {sck_sync[1:0], spi_sck_i};
            cs_sync  <= {cs_sync[1:0], spi_cs_n_i};
            sdi_sync <= {sdi_sync[0], spi_sdi_i};
        end
    end

    assign sck_rise  = sck_sync[1] & ~sck_sync[2];
    assign cs_rise   = cs_sync[1] & ~cs_sync[2];
    assign cs_active = ~cs_sync[1];

    // ========================================================================
    // Frame assembly
    // ========================================================================
    // Counter stops one past a full frame so long frames are rejected too
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            bit_cnt <= '0;
        end else if (!cs_active) begin
            bit_cnt <= '0;
        end else if (sck_rise && bit_cnt <= 5'(FRAME_BITS)) begin
            bit_cnt <= bit_cnt + 5'd1;
        end
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (cs_active && sck_rise) begin
            frame <= {frame[FRAME_BITS-2:0], sdi_sync[1]};   // MSB first
        end
    end

    assign band    = frame.addr[7:4];
    assign tap     = frame.addr[3:0];
    assign addr_ok = (band <= 4'd2) && (tap <= 4'd4);
    assign commit  = cs_rise && (bit_cnt == 5'(FRAME_BITS)) && addr_ok;

    // Coefficient bank
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            coefs_o         <= '0;
            coefs_o.low.b0  <= 16'(COEF_ONE);   // Passthrough setting
            coefs_o.mid.b0  <= 16'(COEF_ONE);
            coefs_o.high.b0 <= 16'(COEF_ONE);
        end else if (commit) begin
            case (band)
                4'd0:    coefs_o.low  <= set_tap(coefs_o.low, tap, frame.data);
                4'd1:    coefs_o.mid  <= set_tap(coefs_o.mid, tap, frame.data);
                default: coefs_o.high <= set_tap(coefs_o.high, tap, frame.data);
            endcase
        end
    end

endmodule

// ==== hw/biquad_cascade.sv ====
module biquad_cascade (
    input  logic                               lmmi_clk_i,
    input  logic                               reset_n_i,
    input  eq_pkg::coef_bank_t                 coefs_i,
    input  logic signed [eq_pkg::SAMPLE_W-1:0] sample_i,
    input  logic                               sample_valid_i,
    output logic signed [eq_pkg::SAMPLE_W-1:0] audio_o,
    output logic                               audio_valid_o
);
    import eq_pkg::*;

    localparam int ACC_W  = 40;
    localparam int PROD_W = 16 + SAMPLE_W;
    localparam logic signed [ACC_W-1:0] SAT_MAX = ACC_W'(2 ** (SAMPLE_W - 1) - 1);
    localparam logic signed [ACC_W-1:0] SAT_MIN = ACC_W'(-(2 ** (SAMPLE_W - 1)));

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MAC,
        ST_FIN
    } state_t;

    state_t                     state;
    logic [1:0]                 sec;        // Active section, low first
    logic [2:0]                 tap;
    coef_bank_t                 coef_q;     // Bank frozen for the current sample
    coef_t                      cur;
    logic signed [SAMPLE_W-1:0] x_cur;      // Input of the active section
    logic signed [SAMPLE_W-1:0] x1 [3];
    logic signed [SAMPLE_W-1:0] x2 [3];
    logic signed [SAMPLE_W-1:0] y1 [3];
    logic signed [SAMPLE_W-1:0] y2 [3];
    logic signed [15:0]         mul_c;
    logic signed [SAMPLE_W-1:0] mul_d;
    logic signed [PROD_W-1:0]   prod;
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    acc_shr;
    logic signed [SAMPLE_W-1:0] y_sat;

    always_comb begin
        case (sec)
            2'd0:    cur = coef_q.low;
            2'd1:    cur = coef_q.mid;
            default: cur = coef_q.high;
        endcase
    end

    // ========================================================================
    // Shared multiplier
    // ========================================================================
    always_comb begin
        mul_c = cur.b0;
        mul_d = x_cur;
        case (tap)
            3'd1: begin
                mul_c = cur.b1;
                mul_d = x1[sec];
            end
            3'd2: begin
                mul_c = cur.b2;
                mul_d = x2[sec];
            end
            3'd3: begin
                mul_c = cur.a1;
                mul_d = y1[sec];
            end
            3'd4: begin
                mul_c = cur.a2;
                mul_d = y2[sec];
            end
            default: ;
        endcase
    end

    assign prod    = mul_c * mul_d;
    assign acc_shr = acc >>> COEF_FRAC;     // Floor toward minus infinity

    always_comb begin
        if (acc_shr > SAT_MAX) begin
            y_sat = SAT_MAX[SAMPLE_W-1:0];
        end else if (acc_shr < SAT_MIN) begin
            y_sat = SAT_MIN[SAMPLE_W-1:0];
        end else begin
            y_sat = acc_shr[SAMPLE_W-1:0];
        end
    end

    // Result is valid in the finalize cycle of the high section
    assign audio_o       = y_sat;
    assign audio_valid_o = (state == ST_FIN) && (sec == 2'd2);

    // ========================================================================
    // Sequencer and section history
    // ========================================================================
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            state <= ST_IDLE;
            sec   <= '0;
            tap   <= '0;
            for (int i = 0; i < 3; i++) begin
                x1[i] <= '0;
                x2[i] <= '0;
                y1[i] <= '0;
                y2[i] <= '0;
            end
        end else begin
            case (state)
                ST_IDLE: begin
                    if (sample_valid_i) begin
                        sec   <= '0;
                        tap   <= '0;
                        state <= ST_MAC;
                    end
                end
                ST_MAC: begin
                    tap <= tap + 3'd1;
                    if (tap == 3'd4) begin
                        state <= ST_FIN;
                    end
                end
                ST_FIN: begin
                    x2[sec] <= x1[sec];
                    x1[sec] <= x_cur;
                    y2[sec] <= y1[sec];
                    y1[sec] <= y_sat;
                    tap     <= '0;
                    if (sec == 2'd2) begin
                        state <= ST_IDLE;
                    end else begin
                        sec   <= sec + 2'd1;
                        state <= ST_MAC;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Accumulator and section input
    always_ff @(posedge lmmi_clk_i) begin
        if (state == ST_IDLE && sample_valid_i) begin
            coef_q <= coefs_i;
            x_cur  <= sample_i;
            acc    <= '0;
        end else if (state == ST_MAC) begin
            if (tap >= 3'd3) begin
                acc <= acc - prod;      // Feedback taps subtract
            end else begin
                acc <= acc + prod;
            end
        end else if (state == ST_FIN) begin
            x_cur <= y_sat;             // Feeds the next section
            acc   <= '0;
        end
    end

endmodule

// ==== hw/i2s_rx.sv ====
module i2s_rx #(
    parameter int DATA_WIDTH = 24,
    parameter int SCK_HALF   = 4
) (
    input  logic                               lmmi_clk_i,
    input  logic                               reset_n_i,
    input  logic                               i2s_sd_i,
    output logic                               i2s_sck_o,
    output logic                               i2s_ws_o,
    output logic                               sck_fall_o,
    output logic                               frame_start_o,
    output logic signed [eq_pkg::SAMPLE_W-1:0] sample_o,
    output logic                               sample_valid_o
);
    import eq_pkg::*;

    localparam int DIV_W = $clog2(SCK_HALF + 1);

    logic [DIV_W-1:0]      div_cnt;
    logic                  half_tick;
    logic                  sck_rise;
    logic [5:0]            bit_cnt;     // Bit clock position in the frame
    logic [5:0]            bit_nxt;
    logic                  left_data;
    logic                  last_bit;
    logic [DATA_WIDTH-1:0] shreg;
    logic [DATA_WIDTH-1:0] word;

    assign half_tick     = (div_cnt == DIV_W'(SCK_HALF - 1));
    assign sck_rise      = half_tick & ~i2s_sck_o;
    assign sck_fall_o    = half_tick & i2s_sck_o;
    assign bit_nxt       = bit_cnt + 6'd1;
    assign frame_start_o = sck_fall_o && (bit_cnt == 6'd63);
    assign left_data     = (bit_cnt >= 6'd1) && (bit_cnt <= 6'(DATA_WIDTH)); // One-bit delay
    assign last_bit      = sck_rise && (bit_cnt == 6'(DATA_WIDTH));
    assign word          = {shreg[DATA_WIDTH-2:0], i2s_sd_i};

    // Bit clock and word select
    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            div_cnt   <= '0;
            i2s_sck_o <= 1'b0;
            bit_cnt   <= '0;
            i2s_ws_o  <= 1'b0;
        end else begin
            div_cnt <= half_tick ? '0 : div_cnt + DIV_W'(1);
            if (half_tick) begin
                i2s_sck_o <= ~i2s_sck_o;
            end
            if (sck_fall_o) begin
                bit_cnt  <= bit_nxt;
                i2s_ws_o <= bit_nxt[5];     // High for the right half
            end
        end
    end

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= last_bit;
        end
    end

    // Left slot capture, upper bits kept
    always_ff @(posedge lmmi_clk_i) begin
        if (sck_rise && left_data) begin
            shreg <= word;
        end
        if (last_bit) begin
            sample_o <= word[DATA_WIDTH-1 -: SAMPLE_W];
        end
    end

endmodule

// ==== hw/i2s_tx.sv ====
module i2s_tx #(
    parameter int DATA_WIDTH = 24
) (
    input  logic                               lmmi_clk_i,
    input  logic                               reset_n_i,
    input  logic                               sck_fall_i,
    input  logic                               frame_start_i,
    input  logic signed [eq_pkg::SAMPLE_W-1:0] audio_i,
    input  logic                               audio_valid_i,
    output logic                               i2s_sd_o
);
    import eq_pkg::*;

    localparam int PAD_W  = DATA_WIDTH - SAMPLE_W;  // Zeros after the sample
    localparam int TAIL_W = 31 - DATA_WIDTH;        // Idle bits to the end of a slot

    logic signed [SAMPLE_W-1:0] held;
    logic [DATA_WIDTH-1:0]      slot;
    logic [63:0]                frame;
    logic [63:0]                shreg;

    assign slot = {held, {PAD_W{1'b0}}};

    // ========================================================================
    // Frame image
    // ========================================================================
    // Each channel is the delay bit, the slot and then idle zeros
    assign frame = {1'b0, slot, {TAIL_W{1'b0}}, 1'b0, slot, {TAIL_W{1'b0}}};

    always_ff @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            held     <= '0;
            shreg    <= '0;
            i2s_sd_o <= 1'b0;
        end else begin
            if (audio_valid_i) begin
                held <= audio_i;                    // Kept until the next result
            end
            if (sck_fall_i) begin
                if (frame_start_i) begin
                    i2s_sd_o <= frame[63];
                    shreg    <= {frame[62:0], 1'b0};
                end else begin
                    i2s_sd_o <= shreg[63];
                    shreg    <= {shreg[62:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== hw/audio_eq_top.sv ====
module audio_eq_top #(
    parameter int DATA_WIDTH = 24,
    parameter int SCK_HALF   = 4
) (
    input  logic lmmi_clk_i,
    input  logic reset_n_i,
    input  logic spi_sck_i,
    input  logic spi_sdi_i,
    input  logic spi_cs_n_i,
    input  logic i2s_sd_i,
    output logic i2s_sd_o,
    output logic i2s_sck_o,
    output logic i2s_ws_o
);
    import eq_pkg::*;

    logic                       sck_fall;       // Bit clock falling strobe
    logic                       frame_start;
    logic signed [SAMPLE_W-1:0] sample;
    logic                       sample_valid;
    coef_bank_t                 coefs;
    logic signed [SAMPLE_W-1:0] audio;
    logic                       audio_valid;

    // ========================================================================
    // Audio path
    // ========================================================================
    i2s_rx #(
        .DATA_WIDTH (DATA_WIDTH),
        .SCK_HALF   (SCK_HALF)
    ) u_rx (
        .lmmi_clk_i     (lmmi_clk_i),
        .reset_n_i      (reset_n_i),
        .i2s_sd_i       (i2s_sd_i),
        .i2s_sck_o      (i2s_sck_o),
        .i2s_ws_o       (i2s_ws_o),
        .sck_fall_o     (sck_fall),
        .frame_start_o  (frame_start),
        .sample_o       (sample),
        .sample_valid_o (sample_valid)
    );

    biquad_cascade u_eq (
        .lmmi_clk_i     (lmmi_clk_i),
        .reset_n_i      (reset_n_i),
        .coefs_i        (coefs),
        .sample_i       (sample),
        .sample_valid_i (sample_valid),
        .audio_o        (audio),
        .audio_valid_o  (audio_valid)
    );

    i2s_tx #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_tx (
        .lmmi_clk_i    (lmmi_clk_i),
        .reset_n_i     (reset_n_i),
        .sck_fall_i    (sck_fall),
        .frame_start_i (frame_start),
        .audio_i       (audio),
        .audio_valid_i (audio_valid),
        .i2s_sd_o      (i2s_sd_o)
    );

    // Coefficient writes from the controller
    spi_coef_regs u_regs (
        .lmmi_clk_i (lmmi_clk_i),
        .reset_n_i  (reset_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_sdi_i  (spi_sdi_i),
        .spi_cs_n_i (spi_cs_n_i),
        .coefs_o    (coefs)
    );

endmodule

// ==== verification/audio_eq_tb.sv ====
module audio_eq_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DW        = 24;              // I2S slot data bits
    localparam int SCK_HALF  = 4;
    localparam int SPI_HALF  = 3;               // System cycles per SPI clock half
    localparam int FRAC_BITS = 14;
    localparam int CH_BITS   = 32;              // Bit clocks per channel
    localparam int FRAME_CYC = 128 * SCK_HALF;  // 64 bit clocks per frame
    // Start-up, passthrough, half gain, saturation, biquad, bad frames, drain
    localparam int N_FRAMES  = 2 + 10 + (3 + 10) + (3 + 6) + (15 + 24) + (3 + 6) + 2;
    localparam int MAX_CYC   = 16 + (N_FRAMES * FRAME_CYC * 3) / 2;
    localparam int T3_COEF [3][5] = '{
        '{4096, 8192, 4096, -14746, 3277},
        '{16384, -8000, 3000, 6000, -2000},
        '{12000, -12000, 2000, -4000, 1500}
    };

    logic lmmi_clk_i = 1'b0;
    logic reset_n_i  = 1'b0;
    logic spi_sck_i  = 1'b0;
    logic spi_sdi_i  = 1'b0;
    logic spi_cs_n_i = 1'b1;
    logic i2s_sd_i   = 1'b0;
    logic i2s_sd_o;
    logic i2s_sck_o;
    logic i2s_ws_o;

    logic          sck_q;
    logic          ws_q;
    int            pos;                 // Bit position inside the current channel
    int            frame_len;           // Cycles since the last left channel start
    logic          frame_seen;
    logic          frame_tick;          // High one cycle after a frame boundary
    logic [DW-1:0] l_next = '0;
    logic [DW-1:0] r_next = '0;
    logic [DW-1:0] r_cur;
    logic [DW-1:0] sh_out;
    logic [DW-1:0] rx_l;
    logic [DW-1:0] rx_r;
    logic [DW-1:0] cap_l;
    logic [DW-1:0] cap_r;

    int          exp_q [$];
    string       name_q [$];
    int          errors = 0;
    int          checks = 0;
    int          bus_errors = 0;
    int          bus_checks = 0;
    int          cycles = 0;
    logic [31:0] rng = 32'h58aeed7e;

    int coef_m [3][5];                  // Model taps b0 b1 b2 a1 a2 per band
    int hx1 [3];
    int hx2 [3];
    int hy1 [3];
    int hy2 [3];

    audio_eq_top #(
        .DATA_WIDTH (DW),
        .SCK_HALF   (SCK_HALF)
    ) dut_i (
        .lmmi_clk_i (lmmi_clk_i),
        .reset_n_i  (reset_n_i),
        .spi_sck_i  (spi_sck_i),
        .spi_sdi_i  (spi_sdi_i),
        .spi_cs_n_i (spi_cs_n_i),
        .i2s_sd_i   (i2s_sd_i),
        .i2s_sd_o   (i2s_sd_o),
        .i2s_sck_o  (i2s_sck_o),
        .i2s_ws_o   (i2s_ws_o)
    );

    always #20 lmmi_clk_i = ~lmmi_clk_i;

    always @(posedge lmmi_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("Timeout: simulation ran past %0d cycles", MAX_CYC);
            $display("Test failures found");
            $finish;
        end
    end

    // ========================================================================
    // I2S bus model, timed from the DUT bit clock and word select
    // ========================================================================
    always @(posedge lmmi_clk_i) begin
        if (!reset_n_i) begin
            sck_q      <= 1'b0;
            ws_q       <= 1'b0;
            pos        <= 0;
            frame_len  <= 0;
            frame_seen <= 1'b0;
            frame_tick <= 1'b0;
            i2s_sd_i   <= 1'b0;
            sh_out     <= '0;
            r_cur      <= '0;
        end else begin
            sck_q      <= i2s_sck_o;
            ws_q       <= i2s_ws_o;
            frame_len  <= frame_len + 1;
            frame_tick <= 1'b0;
            if (sck_q && !i2s_sck_o) begin
                if (i2s_ws_o != ws_q) begin         // Channel start with the one-bit delay
                    bus_checks++;
                    assert (pos == CH_BITS - 1) else begin
                        bus_errors++;
                        $display("mismatch channel_length: expected %0d, actual %0d",
                                 CH_BITS, pos + 1);
                    end
                    pos      <= 0;
                    i2s_sd_i <= 1'b0;
                    if (!i2s_ws_o) begin
                        if (frame_seen) begin
                            bus_checks++;
                            assert (frame_len == FRAME_CYC) else begin
                                bus_errors++;
                                $display("mismatch frame_length: expected %0d, actual %0d",
                                         FRAME_CYC, frame_len);
                            end
                        end
                        frame_len  <= 1;
                        frame_seen <= 1'b1;
                        sh_out     <= l_next;
                        r_cur      <= r_next;
                        cap_l      <= rx_l;
                        cap_r      <= rx_r;
                        frame_tick <= 1'b1;
                    end else begin
                        sh_out <= r_cur;
                    end
                end else begin
                    pos <= pos + 1;
                    if (pos + 1 <= DW) begin
                        i2s_sd_i <= sh_out[DW-1];   // MSB first
                        sh_out   <= sh_out << 1;
                    end else begin
                        i2s_sd_i <= 1'b0;           // Slot padding
                    end
                end
            end else if (!sck_q && i2s_sck_o && pos >= 1 && pos <= DW) begin
                if (i2s_ws_o) begin
                    rx_r <= {rx_r[DW-2:0], i2s_sd_o};
                end else begin
                    rx_l <= {rx_l[DW-2:0], i2s_sd_o};
                end
            end
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic int rand_sample();
        rng = xorshift32(rng);
        return int'($signed(rng[15:0]));
    endfunction

    // Reference filter of three sections in series with floor shift and saturation
    function automatic int model_run(input int x);
        longint acc;
        int     xin;
        int     y;
        xin = x;
        y   = x;
        for (int s = 0; s < 3; s++) begin
            acc = longint'(coef_m[s][0]) * xin + longint'(coef_m[s][1]) * hx1[s]
                + longint'(coef_m[s][2]) * hx2[s] - longint'(coef_m[s][3]) * hy1[s]
                - longint'(coef_m[s][4]) * hy2[s];
            acc = acc >>> FRAC_BITS;
            if (acc > 32767) begin
                y = 32767;
            end else if (acc < -32768) begin
                y = -32768;
            end else begin
                y = int'(acc);
            end
            hx2[s] = hx1[s];
            hx1[s] = xin;
            hy2[s] = hy1[s];
            hy1[s] = y;
            xin    = y;                     // Next section input
        end
        return y;
    endfunction

    task automatic wait_frame();
        do begin
            @(posedge lmmi_clk_i);
        end while (!frame_tick);
    endtask

    // Queues one input per frame and checks the output of two frames back
    task automatic step(input string name, input int x, input int exp_y);
        int            exp_v;
        string         nm;
        logic [DW-1:0] want;
        rng    = xorshift32(rng);
        l_next = {16'(x), rng[DW-17:0]};
        rng    = xorshift32(rng);
        r_next = rng[DW-1:0];               // Right input is junk to the DUT
        exp_q.push_back(exp_y);
        name_q.push_back(name);
        wait_frame();
        if (exp_q.size() > 2) begin
            exp_v  = exp_q.pop_front();
            nm     = name_q.pop_front();
            want   = {16'(exp_v), {(DW-16){1'b0}}};
            checks = checks + 2;
            assert (cap_l == want) else begin
                errors++;
                $display("mismatch %s left: expected %h, actual %h", nm, want, cap_l);
            end
            assert (cap_r == want) else begin
                errors++;
                $display("mismatch %s right: expected %h, actual %h", nm, want, cap_r);
            end
        end
    endtask

    task automatic sample_step(input string name);
        int x;
        x = rand_sample();
        step(name, x, model_run(x));
    endtask

    // Sent in the right half after the left sample has been taken
    task automatic spi_send(input logic [7:0] addr, input logic [15:0] data, input int nbits);
        logic [23:0] bits;
        bits = {addr, data};
        while (!i2s_ws_o) @(posedge lmmi_clk_i);
        @(posedge lmmi_clk_i);
        spi_cs_n_i <= 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spi_sdi_i <= bits[23];
            bits = bits << 1;
            repeat (SPI_HALF) @(posedge lmmi_clk_i);
            spi_sck_i <= 1'b1;
            repeat (SPI_HALF) @(posedge lmmi_clk_i);
            spi_sck_i <= 1'b0;
        end
        repeat (SPI_HALF) @(posedge lmmi_clk_i);
        spi_cs_n_i <= 1'b1;
        spi_sdi_i  <= 1'b0;
        repeat (4) @(posedge lmmi_clk_i);
        if (nbits == 24 && addr[7:4] <= 4'd2 && addr[3:0] <= 4'd4) begin
            coef_m[int'(addr[7:4])][int'(addr[3:0])] = int'($signed(data));
        end
    endtask

    task automatic write_after_sample(input string name, input int band, input int tap,
                                      input int data, input int nbits);
        sample_step(name);
        spi_send({4'(band), 4'(tap)}, 16'(data), nbits);
    endtask

    initial begin
        int x;
        for (int s = 0; s < 3; s++) begin
            coef_m[s] = '{16384, 0, 0, 0, 0};   // Passthrough bank
        end
        repeat (16) @(posedge lmmi_clk_i);
        // Bit clock, word select and serial data idle low in reset
        checks = checks + 1;
        assert ({i2s_sck_o, i2s_ws_o, i2s_sd_o} === 3'b000) else begin
            errors++;
            $display("mismatch reset_state: expected %b, actual %b", 3'b000,
                     {i2s_sck_o, i2s_ws_o, i2s_sd_o});
        end
        reset_n_i <= 1'b1;
        wait_frame();

        // ====================================================================
        // Passthrough, half gain per band, saturation
        // ====================================================================
        for (int i = 0; i < 10; i++) begin
            x = rand_sample();
            void'(model_run(x));
            step("passthrough", x, x);
        end
        for (int b = 0; b < 3; b++) begin
            write_after_sample("half_gain_write", b, 0, 8192, 24);
        end
        for (int i = 0; i < 10; i++) begin
            x = rand_sample();
            void'(model_run(x));
            step("half_gain", x, x >>> 3);      // Floor of x / 8
        end
        for (int b = 0; b < 3; b++) begin
            write_after_sample("saturation_write", b, 0, 32767, 24);
        end
        for (int i = 0; i < 6; i++) begin
            x = (i % 2 == 0) ? 32767 : -32768;
            void'(model_run(x));
            step("saturation", x, (x > 0) ? 32767 : -32768);
        end

        // ====================================================================
        // Full biquads with history, then rejected frames
        // ====================================================================
        for (int b = 0; b < 3; b++) begin
            for (int t = 0; t < 5; t++) begin
                write_after_sample("biquad_write", b, t, T3_COEF[b][t], 24);
            end
        end
        for (int i = 0; i < 24; i++) begin
            sample_step("biquad");
        end
        write_after_sample("short_frame", 0, 0, 0, 20);
        write_after_sample("bad_band", 3, 0, 0, 24);
        write_after_sample("bad_tap", 1, 7, 0, 24);
        for (int i = 0; i < 6; i++) begin
            sample_step("after_bad_frames");
        end
        sample_step("drain");
        sample_step("drain");

        $display("Checks run: %0d, errors: %0d", checks + bus_checks, errors + bus_errors);
        if (errors + bus_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== audio_eq.f ====
hw/eq_pkg.sv
hw/spi_coef_regs.sv
hw/biquad_cascade.sv
hw/i2s_rx.sv
hw/i2s_tx.sv
hw/audio_eq_top.sv
verification/audio_eq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the audio equalizer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module audio_eq_tb -f audio_eq.f -o audio_eq_sim > build.log 2>&1 \
    && ./obj_dir/audio_eq_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
